// ==== rtl/muldiv_pkg.sv ====
// muldiv package, shared word types and encodings for the multiply/divide unit.
package muldiv_pkg;

    parameter int XLEN = 64; // architectural word width.

    typedef logic [XLEN-1:0]   xlen_t;  // one operand or result word.
    typedef logic [2*XLEN-1:0] dword_t; // full double-width product.

    // operation codes of the M extension, word forms last.
    typedef enum logic [3:0] {
        OP_MUL    = 4'd0,
        OP_MULH   = 4'd1,
        OP_MULHSU = 4'd2,
        OP_MULHU  = 4'd3,
        OP_DIV    = 4'd4,
        OP_DIVU   = 4'd5,
        OP_REM    = 4'd6,
        OP_REMU   = 4'd7,
        OP_MULW   = 4'd8,
        OP_DIVW   = 4'd9,
        OP_DIVUW  = 4'd10,
        OP_REMW   = 4'd11,
        OP_REMUW  = 4'd12
    } muldiv_op_e;

    // both iterative engines share this state encoding.
    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_RUN  = 1'b1
    } engine_state_e;

endpackage

// ==== rtl/muldiv_operand_prep.sv ====
// muldiv operand stage that latches the operation and forms magnitudes, sign and special flags.
module muldiv_operand_prep (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  muldiv_pkg::muldiv_op_e op,
    input  muldiv_pkg::xlen_t      src_a,
    input  muldiv_pkg::xlen_t      src_b,
    input  logic                   done,
    output logic                   busy,
    output logic                   mul_go,
    output logic                   div_go,
    output muldiv_pkg::xlen_t      mag_a,
    output muldiv_pkg::xlen_t      mag_b,
    output muldiv_pkg::muldiv_op_e op_q,
    output logic                   neg_result,
    output logic                   div_zero,
    output logic                   div_ovf,
    output muldiv_pkg::xlen_t      a_word
);
    import muldiv_pkg::*;

    logic  accept;
    logic  is_mul;
    logic  a_signed;
    logic  b_signed;
    logic  use_a_sign; // result sign follows the dividend only.
    logic  word_sext;
    logic  word_zext;
    logic  sa;
    logic  sb;
    xlen_t red_a;
    xlen_t red_b;
    xlen_t min_neg;

    assign accept = start & ~busy;

    always_comb begin
        is_mul     = 1'b0;
        a_signed   = 1'b0;
        b_signed   = 1'b0;
        use_a_sign = 1'b0;
        word_sext  = 1'b0;
        word_zext  = 1'b0;
        unique case (op)
            OP_MUL:    is_mul = 1'b1; // low half is sign independent.
            OP_MULH:   begin
                is_mul   = 1'b1;
                a_signed = 1'b1;
                b_signed = 1'b1;
            end
            OP_MULHSU: begin
                is_mul     = 1'b1;
                a_signed   = 1'b1;
                use_a_sign = 1'b1;
            end
            OP_MULHU:  is_mul = 1'b1;
            OP_DIV:    begin
                a_signed = 1'b1;
                b_signed = 1'b1;
            end
            OP_REM:    begin
                a_signed   = 1'b1;
                b_signed   = 1'b1;
                use_a_sign = 1'b1;
            end
            OP_MULW:   begin
                is_mul    = 1'b1;
                word_zext = 1'b1;
            end
            OP_DIVW:   begin
                a_signed  = 1'b1;
                b_signed  = 1'b1;
                word_sext = 1'b1;
            end
            OP_REMW:   begin
                a_signed   = 1'b1;
                b_signed   = 1'b1;
                use_a_sign = 1'b1;
                word_sext  = 1'b1;
            end
            OP_DIVUW, OP_REMUW: word_zext = 1'b1;
            default: ; // divu and remu need no flags.
        endcase
    end

    // reduce word forms to 64 bits.
    assign red_a = word_sext ? {{(XLEN-32){src_a[31]}}, src_a[31:0]} :
                   word_zext ? {{(XLEN-32){1'b0}}, src_a[31:0]} : src_a;
    assign red_b = word_sext ? {{(XLEN-32){src_b[31]}}, src_b[31:0]} :
                   word_zext ? {{(XLEN-32){1'b0}}, src_b[31:0]} : src_b;

    assign sa      = a_signed & red_a[XLEN-1];
    assign sb      = b_signed & red_b[XLEN-1];
    assign min_neg = word_sext ? {{(XLEN-31){1'b1}}, {31{1'b0}}} : {1'b1, {(XLEN-1){1'b0}}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            mul_go <= 1'b0;
            div_go <= 1'b0;
        end else begin
            mul_go <= accept & is_mul;
            div_go <= accept & ~is_mul;
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q       <= op;
            mag_a      <= sa ? -red_a : red_a;
            mag_b      <= sb ? -red_b : red_b;
            neg_result <= use_a_sign ? sa : (sa ^ sb);
            div_zero   <= ~is_mul & (red_b == '0);
            div_ovf    <= ~is_mul & a_signed & (red_a == min_neg) & (red_b == '1);
            a_word     <= red_a;
        end
    end

    // the result stage only reports done for an operation in flight.
    a_done_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> busy);

endmodule

// ==== rtl/mul_shift_add.sv ====
// shift-add multiplier, unsigned iterative product of two WIDTH-bit magnitudes.
module mul_shift_add #(
    parameter int WIDTH = 64
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 go,
    input  logic [WIDTH-1:0]     mag_a,
    input  logic [WIDTH-1:0]     mag_b,
    output logic                 done,
    output logic [2*WIDTH-1:0]   product
);
    import muldiv_pkg::*;

    localparam int CW = $clog2(WIDTH);
    localparam logic [CW-1:0] LAST = CW'(WIDTH - 1);

    engine_state_e    state;
    logic [CW-1:0]    cnt;
    logic [WIDTH-1:0] mcand;
    logic [2*WIDTH-1:0] acc;  // upper half partial sum, lower half multiplier.
    logic [WIDTH:0]   upper;  // carry out of the add.

    // add the multiplicand when the current multiplier bit is set.
    always_comb begin
        if (acc[0]) begin
            upper = {1'b0, acc[2*WIDTH-1:WIDTH]} + {1'b0, mcand};
        end else begin
            upper = {1'b0, acc[2*WIDTH-1:WIDTH]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            unique case (state)
                ST_IDLE: begin
                    if (go) begin
                        state <= ST_RUN;
                        cnt   <= '0;
                    end
                end
                ST_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == LAST) begin
                        state <= ST_IDLE;
                        done  <= 1'b1; // product is complete from here on.
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            if (go) begin
                mcand <= mag_a;
                acc   <= {{WIDTH{1'b0}}, mag_b};
            end
        end else begin
            acc <= {upper, acc[WIDTH-1:1]}; // shift right one bit.
        end
    end

    assign product = acc;

    a_go_idle: assert property (@(posedge clk) disable iff (!rst_n) !(go && state == ST_RUN));

endmodule

// ==== rtl/div_restoring.sv ====
// restoring divider giving the unsigned quotient and remainder of WIDTH-bit magnitudes.
module div_restoring #(
    parameter int WIDTH = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             go,
    input  logic [WIDTH-1:0] mag_a,
    input  logic [WIDTH-1:0] mag_b,
    output logic             done,
    output logic [WIDTH-1:0] quotient,
    output logic [WIDTH-1:0] remainder
);
    import muldiv_pkg::*;

    localparam int CW = $clog2(WIDTH);
    localparam logic [CW-1:0] LAST = CW'(WIDTH - 1);

    engine_state_e    state;
    logic [CW-1:0]    cnt;
    logic [WIDTH-1:0] dvsr;
    logic [WIDTH-1:0] rem;
    logic [WIDTH-1:0] quo;  // dividend shifts out as quotient bits shift in.
    logic [WIDTH:0]   trial;
    logic [WIDTH:0]   diff;
    logic             fits;

    // next partial remainder with one dividend bit brought in.
    assign trial = {rem, quo[WIDTH-1]};
    assign diff  = trial - {1'b0, dvsr};
    assign fits  = (trial >= {1'b0, dvsr}); // full width compare.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            unique case (state)
                ST_IDLE: begin
                    if (go) begin
                        state <= ST_RUN;
                        cnt   <= '0;
                    end
                end
                ST_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == LAST) begin
                        state <= ST_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // a zero divisor always fits and gives all ones and the dividend back.
    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            if (go) begin
                dvsr <= mag_b;
                rem  <= '0;
                quo  <= mag_a;
            end
        end else begin
            if (fits) begin
                rem <= diff[WIDTH-1:0];
            end else begin
                rem <= trial[WIDTH-1:0];
            end
            quo <= {quo[WIDTH-2:0], fits};
        end
    end

    assign quotient  = quo;
    assign remainder = rem;

    a_go_idle: assert property (@(posedge clk) disable iff (!rst_n) !(go && state == ST_RUN));

endmodule

// ==== rtl/muldiv_result_fixup.sv ====
// muldiv result stage, applies sign, picks the half and registers the final word.
module muldiv_result_fixup (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mul_done,
    input  muldiv_pkg::dword_t     product,
    input  logic                   div_done,
    input  muldiv_pkg::xlen_t      quotient,
    input  muldiv_pkg::xlen_t      remainder,
    input  muldiv_pkg::muldiv_op_e op_q,
    input  logic                   neg_result,
    input  logic                   div_zero,
    input  logic                   div_ovf,
    input  muldiv_pkg::xlen_t      a_word,
    output logic                   done,
    output muldiv_pkg::xlen_t      result
);
    import muldiv_pkg::*;

    dword_t prod_s;
    xlen_t  mul_res;
    xlen_t  quo_s;
    xlen_t  rem_s;
    xlen_t  div_res;
    xlen_t  pick;
    xlen_t  res_nxt;
    logic   is_rem;
    logic   is_word;

    assign prod_s  = neg_result ? -product : product;
    assign mul_res = (op_q == OP_MUL || op_q == OP_MULW) ? prod_s[XLEN-1:0]
                                                         : prod_s[2*XLEN-1:XLEN];

    assign is_rem  = (op_q == OP_REM) || (op_q == OP_REMU) ||
                     (op_q == OP_REMW) || (op_q == OP_REMUW);
    assign is_word = (op_q == OP_MULW) || (op_q == OP_DIVW) || (op_q == OP_DIVUW) ||
                     (op_q == OP_REMW) || (op_q == OP_REMUW);

    always_comb begin
        if (div_zero) begin
            quo_s = '1;      // sign is ignored on a zero divisor.
            rem_s = a_word;
        end else if (div_ovf) begin
            quo_s = a_word;
            rem_s = '0;
        end else begin
            // neg_result already carries the sign for this op.
            quo_s = neg_result ? -quotient : quotient;
            rem_s = neg_result ? -remainder : remainder;
        end
    end

    assign div_res = is_rem ? rem_s : quo_s;
    assign pick    = mul_done ? mul_res : div_res;
    assign res_nxt = is_word ? {{(XLEN-32){pick[31]}}, pick[31:0]} : pick;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= mul_done | div_done;
            if (mul_done || div_done) begin
                result <= res_nxt; // held until the next operation.
            end
        end
    end

    a_single_src: assert property (@(posedge clk) disable iff (!rst_n)
        !(mul_done && div_done));

endmodule

// ==== rtl/muldiv_unit.sv ====
// muldiv unit top, M extension multiply/divide with start, busy and done strobes.
module muldiv_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  muldiv_pkg::muldiv_op_e op,
    input  muldiv_pkg::xlen_t      src_a,
    input  muldiv_pkg::xlen_t      src_b,
    output logic                   busy,
    output logic                   done,
    output muldiv_pkg::xlen_t      result
);
    import muldiv_pkg::*;

    logic       mul_go;
    logic       div_go;
    xlen_t      mag_a;
    xlen_t      mag_b;
    muldiv_op_e op_q;
    logic       neg_result;
    logic       div_zero;
    logic       div_ovf;
    xlen_t      a_word;
    logic       mul_done;
    dword_t     product;
    logic       div_done;
    xlen_t      quotient;
    xlen_t      remainder;

    muldiv_operand_prep u_prep (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .op         (op),
        .src_a      (src_a),
        .src_b      (src_b),
        .done       (done),
        .busy       (busy),
        .mul_go     (mul_go),
        .div_go     (div_go),
        .mag_a      (mag_a),
        .mag_b      (mag_b),
        .op_q       (op_q),
        .neg_result (neg_result),
        .div_zero   (div_zero),
        .div_ovf    (div_ovf),
        .a_word     (a_word)
    );

    mul_shift_add #(.WIDTH(XLEN)) u_mul (
        .clk     (clk),
        .rst_n   (rst_n),
        .go      (mul_go),
        .mag_a   (mag_a),
        .mag_b   (mag_b),
        .done    (mul_done),
        .product (product)
    );

    div_restoring #(.WIDTH(XLEN)) u_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .go        (div_go),
        .mag_a     (mag_a),
        .mag_b     (mag_b),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    muldiv_result_fixup u_fixup (
        .clk        (clk),
        .rst_n      (rst_n),
        .mul_done   (mul_done),
        .product    (product),
        .div_done   (div_done),
        .quotient   (quotient),
        .remainder  (remainder),
        .op_q       (op_q),
        .neg_result (neg_result),
        .div_zero   (div_zero),
        .div_ovf    (div_ovf),
        .a_word     (a_word),
        .done       (done),
        .result     (result)
    );

endmodule

// ==== dv/muldiv_tb.sv ====
// directed testbench that checks the multiply/divide unit against a reference model.
module muldiv_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import muldiv_pkg::*;

    logic       clk;
    logic       rst_n;
    logic       start;
    muldiv_op_e op;
    xlen_t      src_a;
    xlen_t      src_b;
    logic       busy;
    logic       done;
    xlen_t      result;

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;

    muldiv_unit UUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .op     (op),
        .src_a  (src_a),
        .src_b  (src_b),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1.
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic xlen_t rand_word();
        xlen_t w;
        w = '0;
        for (int i = 0; i < XLEN; i++) begin
            w = {w[XLEN-2:0], lfsr_step()};
        end
        return w;
    endfunction

    function automatic logic [31:0] rand_half();
        logic [31:0] h;
        h = '0;
        for (int i = 0; i < 32; i++) begin
            h = {h[30:0], lfsr_step()};
        end
        return h;
    endfunction

    // riscv m extension rules with word forms on the low 32 bits.
    function automatic xlen_t model_result(muldiv_op_e o, xlen_t a, xlen_t b);
        logic [127:0]       wide_a;
        logic [127:0]       wide_b;
        logic [127:0]       prod;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [31:0] wa;
        logic signed [31:0] wb;
        logic [31:0]        ua;
        logic [31:0]        ub;
        logic [31:0]        w;
        logic               ovf;
        logic               ovf_w;
        xlen_t              r;
        sa     = a;
        sb     = b;
        wa     = a[31:0];
        wb     = b[31:0];
        ua     = a[31:0];
        ub     = b[31:0];
        ovf    = (a == {1'b1, 63'd0}) && (b == '1);
        ovf_w  = (ua == 32'h8000_0000) && (ub == 32'hffff_ffff);
        w      = '0;
        r      = '0;
        wide_a = {64'd0, a};
        wide_b = {64'd0, b};
        case (o)
            OP_MUL:    r = a * b;
            OP_MULH:   begin
                wide_a = {{64{a[63]}}, a};
                wide_b = {{64{b[63]}}, b};
            end
            OP_MULHSU: wide_a = {{64{a[63]}}, a};
            OP_DIV:    r = (b == '0) ? '1 : ovf ? a : xlen_t'(sa / sb);
            OP_DIVU:   r = (b == '0) ? '1 : a / b;
            OP_REM:    r = (b == '0) ? a : ovf ? '0 : xlen_t'(sa % sb);
            OP_REMU:   r = (b == '0) ? a : a % b;
            OP_MULW:   w = ua * ub;
            OP_DIVW:   w = (ub == '0) ? '1 : ovf_w ? ua : 32'(wa / wb);
            OP_DIVUW:  w = (ub == '0) ? '1 : ua / ub;
            OP_REMW:   w = (ub == '0) ? ua : ovf_w ? '0 : 32'(wa % wb);
            OP_REMUW:  w = (ub == '0) ? ua : ua % ub;
            default:   r = '0;
        endcase
        prod = wide_a * wide_b; // only the high half forms use this.
        if (o == OP_MULH || o == OP_MULHSU || o == OP_MULHU) begin
            r = prod[127:64];
        end
        if (o >= OP_MULW) begin
            r = {{32{w[31]}}, w};
        end
        return r;
    endfunction

    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // one operation from start to done.
    task automatic run_op(input muldiv_op_e o, input xlen_t a, input xlen_t b,
                          output xlen_t res);
        int   cycles;
        logic got;
        @(negedge clk);
        start = 1'b1;
        op    = o;
        src_a = a;
        src_b = b;
        @(negedge clk);
        start  = 1'b0;
        cycles = 0;
        got    = 1'b0;
        while (!got && cycles < 200) begin
            @(negedge clk);
            cycles++;
            got = done;
        end
        if (!got) begin
            errors++;
            $display("timeout: %s gave no done within 200 cycles", o.name());
        end
        res = result;
    endtask

    task automatic test_op(input muldiv_op_e o, input xlen_t a, input xlen_t b);
        xlen_t res;
        string name;
        name = $sformatf("%s a=%h b=%h", o.name(), a, b);
        run_op(o, a, b, res);
        check_word(name, model_result(o, a, b), res);
    endtask

    task automatic test_reset();
        check_level("reset busy", 1'b0, busy);
        check_level("reset done", 1'b0, done);
        check_word("reset result", '0, result);
    endtask

    task automatic test_mul();
        xlen_t corner [4];
        xlen_t a;
        xlen_t b;
        corner[0] = 64'd1;
        corner[1] = '1;                  // minus one.
        corner[2] = {1'b1, 63'd0};
        corner[3] = {1'b0, {63{1'b1}}};
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                test_op(OP_MUL, corner[i], corner[j]);
                test_op(OP_MULH, corner[i], corner[j]);
                test_op(OP_MULHSU, corner[i], corner[j]);
                test_op(OP_MULHU, corner[i], corner[j]);
            end
        end
        for (int k = 0; k < 20; k++) begin
            a = rand_word();
            b = rand_word();
            test_op(OP_MUL, a, b);
            test_op(OP_MULH, a, b);
            test_op(OP_MULHSU, a, b);
            test_op(OP_MULHU, a, b);
        end
    endtask

    task automatic div_set(input xlen_t a, input xlen_t b);
        test_op(OP_DIV, a, b);
        test_op(OP_DIVU, a, b);
        test_op(OP_REM, a, b);
        test_op(OP_REMU, a, b);
    endtask

    task automatic test_div();
        div_set(64'd7, 64'd2);
        div_set(-64'sd7, 64'd2);
        div_set(64'd7, -64'sd2);
        div_set(-64'sd7, -64'sd2);
        div_set(64'd12345, 64'd0);   // zero divisor.
        div_set(-64'sd5, 64'd0);
        div_set({1'b1, 63'd0}, '1);  // signed overflow.
        div_set({1'b1, 63'd0}, 64'd1);
        div_set(64'd0, 64'd5);
        for (int k = 0; k < 20; k++) begin
            div_set(rand_word(), rand_word());
        end
        div_set(rand_word(), {32'd0, rand_half()}); // small divisor.
    endtask

    task automatic word_set(input xlen_t a, input xlen_t b);
        test_op(OP_MULW, a, b);
        test_op(OP_DIVW, a, b);
        test_op(OP_DIVUW, a, b);
        test_op(OP_REMW, a, b);
        test_op(OP_REMUW, a, b);
    endtask

    task automatic test_word();
        xlen_t a;
        xlen_t b;
        word_set({rand_half(), 32'h8000_0000}, {rand_half(), 32'hffff_ffff});
        word_set({rand_half(), 32'h0000_1234}, {rand_half(), 32'h0});
        word_set({rand_half(), -32'sd7}, {rand_half(), 32'd2});
        for (int k = 0; k < 10; k++) begin
            a = rand_word();
            b = rand_word();
            word_set(a, b);
            // same low halves under new upper bits.
            word_set({rand_half(), a[31:0]}, {rand_half(), b[31:0]});
        end
    endtask

    task automatic test_timing();
        xlen_t a;
        xlen_t b;
        int    extra;
        a = rand_word();
        b = rand_word();
        extra = 0;
        @(negedge clk);
        start = 1'b1;
        op    = OP_MUL;
        src_a = a;
        src_b = b;
        @(negedge clk);
        start = 1'b0;
        for (int i = 1; i <= 66; i++) begin
            @(negedge clk);
            if (i == 20) begin
                start = 1'b1; // arrives while busy.
                op    = OP_DIVU;
                src_a = rand_word();
                src_b = 64'd3;
            end else if (i == 21) begin
                start = 1'b0;
            end
            check_level($sformatf("timing done at cycle %0d", i), logic'(i == 66), done);
            check_level($sformatf("timing busy at cycle %0d", i), 1'b1, busy);
        end
        check_word("timing result", model_result(OP_MUL, a, b), result);
        @(negedge clk);
        check_level("timing done width", 1'b0, done);
        check_level("timing busy after done", 1'b0, busy);
        for (int i = 0; i < 80; i++) begin
            @(negedge clk);
            if (done) begin
                extra++;
            end
        end
        check_level("timing second done", 1'b0, logic'(extra != 0));
        check_word("timing result held", model_result(OP_MUL, a, b), result);
    endtask

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        op         = OP_MUL;
        src_a      = '0;
        src_b      = '0;
        errors     = 0;
        checks     = 0;
        lfsr_state = 32'd86577;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset();
        test_mul();
        test_div();
        test_word();
        test_timing();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== muldiv.f ====
rtl/muldiv_pkg.sv
rtl/muldiv_operand_prep.sv
rtl/mul_shift_add.sv
rtl/div_restoring.sv
rtl/muldiv_result_fixup.sv
rtl/muldiv_unit.sv
dv/muldiv_tb.sv
